// File: sources.f
+incdir+verilog
+incdir+testbench
verilog/bus_pkg.sv
verilog/io_pkg.sv
verilog/address_decoder.sv
verilog/system_memory.sv
verilog/io_ports.sv
verilog/ms_timer.sv
verilog/video_timer.sv
verilog/aznable_system.sv
testbench/tb_aznable_system.sv

// File: testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// every task starts and ends 1 ns past a rising edge
task automatic step();
	@(posedge clk_24);
	#1;
endtask

task automatic wait_cycles(input int n);
	repeat (n) step();
endtask

task automatic check_data(input cpu_data_t got, input cpu_data_t exp, input string what);
	if (got !== exp)
	begin
		fail_now($sformatf("MISMATCH at %0t: %s read %02h, expected %02h", $time, what, got, exp));
	end
endtask

task automatic check_count(input ms_count_t got, input ms_count_t exp, input string what);
	if (got !== exp)
	begin
		fail_now($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp)
	begin
		fail_now($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
	end
endtask

task automatic check_pulses(input int got, input int exp, input string what);
	if (got != exp)
	begin
		fail_now($sformatf("MISMATCH at %0t: %s counted %0d, expected %0d", $time, what, got, exp));
	end
endtask

task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data);
	cpu_addr = addr;
	cpu_dout = data;
	cpu_wr_n = 1'b0;
	step();
	cpu_wr_n = 1'b1;
endtask

task automatic read_expect(input cpu_addr_t addr, input cpu_data_t exp, input string what);
	cpu_addr = addr;
	step();
	check_data(cpu_din, exp, $sformatf("%s at %04h", what, addr));
endtask

task automatic download(input dn_addr_t addr, input cpu_data_t data, input dn_index_t index);
	dn_addr = addr;
	dn_data = data;
	dn_index = index;
	dn_wr = 1'b1;
	step();
	dn_wr = 1'b0;
endtask

// byte k is bits 8k+7:8k, past the device size reads zero
function automatic cpu_data_t device_byte(input logic [255:0] wide, input int idx, input int nbytes);
	if (idx >= nbytes)
	begin
		return 8'h00;
	end
	return cpu_data_t'(wide >> (8 * idx));
endfunction

function automatic cpu_data_t in0_byte(input logic hs, input logic vs, input logic hb,
	input logic vb, input logic menu_level);
	return {hs, vs, hb, vb, 2'b10, menu_level, 1'b0};
endfunction

task automatic test_memory();
	cpu_addr_t rom_addr [16];
	cpu_data_t rom_data [16];
	cpu_addr_t ram_addr [16];
	cpu_data_t ram_data [16];
	// one address per 2 KiB slice keeps them distinct, loader upper bits are ignored
	for (int i = 0; i < 16; i++)
	begin
		rom_addr[i] = cpu_addr_t'(i * 2048 + $urandom % 2048);
		rom_data[i] = cpu_data_t'($urandom);
		download(dn_addr_t'({9'($urandom), rom_addr[i][14:0]}), rom_data[i], `AZ_DN_INDEX_PGROM);
	end
	download(dn_addr_t'(rom_addr[0]), ~rom_data[0], 8'd1);
	cpu_write(rom_addr[1], ~rom_data[1]);
	for (int i = 0; i < 16; i++)
	begin
		read_expect(rom_addr[i], rom_data[i], "program ROM");
	end
	for (int i = 0; i < 16; i++)
	begin
		ram_addr[i] = cpu_addr_t'(`AZ_WKRAM_BASE + i * 1024 + $urandom % 1024);
		ram_data[i] = cpu_data_t'($urandom);
		cpu_write(ram_addr[i], ram_data[i]);
	end
	for (int i = 0; i < 16; i++)
	begin
		read_expect(ram_addr[i], ram_data[i], "work RAM");
	end
	read_expect(16'h8200, 8'h00, "unmapped page");
	read_expect(16'h8A00, 8'h00, "unmapped page");
	read_expect(16'h8001, 8'h00, "unmapped address");
endtask

task automatic test_input_bytes();
	for (int k = 0; k < 6; k++)
	begin
		joystick[32 * k +: 32] = $urandom;
	end
	paddle = paddle_t'({$urandom, $urandom});
	timestamp = timestamp_t'({$urandom, $urandom});
	for (int idx = 0; idx < 32; idx++)
	begin
		read_expect({`AZ_JOY_PAGE, 8'(idx)},
			device_byte(256'(joystick), idx, `AZ_JOY_BYTES), "joystick byte");
		read_expect({`AZ_PADDLE_PAGE, 8'(idx)},
			device_byte(256'(paddle), idx, `AZ_PADDLE_BYTES), "paddle byte");
		read_expect({`AZ_TSTAMP_PAGE, 8'(idx)},
			device_byte(256'(timestamp), idx, `AZ_TSTAMP_BYTES), "timestamp byte");
	end
endtask

task automatic test_ms_timer();
	cpu_data_t lo;
	cpu_data_t hi;
	// the clear restarts the prescaler, so whole milliseconds follow
	cpu_write({`AZ_TIMER_PAGE, 8'h00}, 8'h00);
	wait_cycles(3 * `AZ_MS_DIVIDE);
	cpu_addr = {`AZ_TIMER_PAGE, 8'h00};
	step();
	lo = cpu_din;
	cpu_addr = {`AZ_TIMER_PAGE, 8'h01};
	step();
	hi = cpu_din;
	check_count({hi, lo}, 16'd3, "timer after three milliseconds");
	for (int idx = 2; idx < 32; idx++)
	begin
		read_expect({`AZ_TIMER_PAGE, 8'(idx)}, 8'h00, "timer byte past its size");
	end
endtask

task automatic test_menu_trigger();
	read_expect(`AZ_IO_BASE, in0_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), "in0 with menu low");
	read_expect(`AZ_MENU_ADDR, 8'h00, "menu trigger idle");
	menu = 1'b1;
	read_expect(`AZ_IO_BASE, in0_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), "in0 with menu high");
	menu = 1'b0;
	read_expect(`AZ_IO_BASE, in0_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), "in0 after menu pulse");
	read_expect(`AZ_MENU_ADDR, 8'hFF, "menu trigger set");
	cpu_write(`AZ_MENU_ADDR, 8'h00);
	read_expect(`AZ_MENU_ADDR, 8'h00, "menu trigger after write");
endtask

task automatic test_pause_trigger();
	check_flag(cpu_wait_n, 1'b1, "cpu_wait_n before pause write");
	cpu_write(`AZ_PAUSE_ADDR, 8'h00);
	check_flag(cpu_wait_n, 1'b0, "cpu_wait_n after pause write");
	wait_cycles(2);
	check_flag(cpu_wait_n, 1'b0, "cpu_wait_n held by trigger");
	pause = 1'b1;
	step();
	check_flag(cpu_wait_n, 1'b0, "cpu_wait_n while pause high");
	pause = 1'b0;
	step();
	check_flag(cpu_wait_n, 1'b1, "cpu_wait_n after pause release");
endtask

// one clock with ce_6 on every fourth, levels sampled at the falling edge
task automatic video_cycle(output logic vb, output logic hb, output logic fired);
	ce_6 = (ce_phase == 0);
	ce_phase = (ce_phase + 1) % 4;
	@(negedge clk_24);
	fired = ce_6;
	vb = vga_vb;
	hb = vga_hb;
	if (fired)
	begin
		ce_pulses = ce_pulses + 1;
	end
	@(posedge clk_24);
	#1;
endtask

task automatic test_video_timing();
	logic vb;
	logic hb;
	logic fired;
	logic vb_prev;
	logic hb_prev;
	logic seen;
	logic hs_exp;
	logic vs_exp;
	int frame_pulses;
	int line_pulses;
	int p;
	int h;
	int v;
	ce_phase = 0;
	ce_pulses = 0;
	vb_prev = 1'b1;
	seen = 1'b0;
	while (!seen)
	begin
		video_cycle(vb, hb, fired);
		seen = vb && !vb_prev;
		vb_prev = vb;
	end
	// the pulse seen with the first blanking sample opens the frame
	frame_pulses = int'(fired);
	seen = 1'b0;
	while (!seen)
	begin
		video_cycle(vb, hb, fired);
		seen = vb && !vb_prev;
		vb_prev = vb;
		if (!seen)
		begin
			frame_pulses = frame_pulses + int'(fired);
		end
	end
	check_pulses(frame_pulses, `AZ_H_TOTAL * `AZ_V_TOTAL, "ce_6 pulses per frame");
	hb_prev = hb;
	seen = 1'b0;
	while (!seen)
	begin
		video_cycle(vb, hb, fired);
		seen = hb && !hb_prev;
		hb_prev = hb;
	end
	line_pulses = 0;
	seen = 1'b0;
	while (!seen)
	begin
		video_cycle(vb, hb, fired);
		seen = hb && !hb_prev;
		hb_prev = hb;
		if (fired && !hb)
		begin
			line_pulses = line_pulses + 1;
		end
	end
	check_pulses(line_pulses, `AZ_H_ACTIVE, "active pulses per line");
	// run until the beam is inside both sync windows, then freeze it
	hs_exp = 1'b0;
	vs_exp = 1'b0;
	while (!(hs_exp && vs_exp))
	begin
		video_cycle(vb, hb, fired);
		p = ce_pulses % (`AZ_H_TOTAL * `AZ_V_TOTAL);
		h = p % `AZ_H_TOTAL;
		v = p / `AZ_H_TOTAL;
		hs_exp = (h >= `AZ_HS_START) && (h < `AZ_HS_END);
		vs_exp = (v >= `AZ_VS_START) && (v < `AZ_VS_END);
	end
	ce_6 = 1'b0;
	check_flag(vga_hs, hs_exp, "vga_hs with video stopped");
	check_flag(vga_vs, vs_exp, "vga_vs with video stopped");
	read_expect(`AZ_IO_BASE, in0_byte(hs_exp, vs_exp, h >= `AZ_H_ACTIVE, v >= `AZ_V_ACTIVE, 1'b0),
		"in0 with video stopped");
endtask

`endif

// File: testbench/tb_aznable_system.sv
`timescale 1ns/10ps
`include "aznable_consts.svh"

module tb_aznable_system
	import bus_pkg::*;
	import io_pkg::*;
();

	localparam int FRAME_CYCLES = 4 * `AZ_H_TOTAL * `AZ_V_TOTAL;
	// timer wait, just under two frames to the second vb edge, a few lines, bus traffic
	localparam int RUN_CYCLES = 3 * `AZ_MS_DIVIDE + 2 * FRAME_CYCLES + 16 * `AZ_H_TOTAL + 10000;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 5;

	logic clk_24;
	logic rst_n;
	logic ce_6;
	logic pause;
	logic menu;
	dn_addr_t dn_addr;
	cpu_data_t dn_data;
	logic dn_wr;
	dn_index_t dn_index;
	joystick_t joystick;
	paddle_t paddle;
	timestamp_t timestamp;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_dout;
	logic cpu_wr_n;
	cpu_data_t cpu_din;
	logic cpu_wait_n;
	logic vga_hs;
	logic vga_vs;
	logic vga_hb;
	logic vga_vb;
	int cycle_count;
	int ce_phase;
	int ce_pulses;

	aznable_system dut_i
	(
		.clk_24(clk_24),
		.rst_n(rst_n),
		.ce_6(ce_6),
		.pause(pause),
		.menu(menu),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.dn_wr(dn_wr),
		.dn_index(dn_index),
		.joystick(joystick),
		.paddle(paddle),
		.timestamp(timestamp),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr_n(cpu_wr_n),
		.cpu_din(cpu_din),
		.cpu_wait_n(cpu_wait_n),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb)
	);

	always
	begin
		#50 clk_24 = ~clk_24;
	end

	always @(posedge clk_24)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			fail_now($sformatf("timeout: tests still running after %0d cycles", cycle_count));
		end
	end

	task automatic fail_now(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_tasks.svh"

	initial
	begin
		clk_24 = 1'b0;
		rst_n = 1'b0;
		ce_6 = 1'b0;
		pause = 1'b0;
		menu = 1'b0;
		dn_addr = '0;
		dn_data = '0;
		dn_wr = 1'b0;
		dn_index = '0;
		joystick = '0;
		paddle = '0;
		timestamp = '0;
		cpu_addr = 16'h8200;
		cpu_dout = '0;
		cpu_wr_n = 1'b1;
		cycle_count = 0;
		ce_phase = 0;
		ce_pulses = 0;
		void'($urandom(40592));
		repeat (3) @(posedge clk_24);
		#1;
		rst_n = 1'b1;
		check_data(cpu_din, 8'h00, "cpu_din after reset");
		check_flag(cpu_wait_n, 1'b1, "cpu_wait_n after reset");
		test_memory();
		test_input_bytes();
		test_ms_timer();
		test_menu_trigger();
		test_pause_trigger();
		test_video_timing();
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: verilog/address_decoder.sv
`timescale 1ns/10ps
`include "aznable_consts.svh"

module address_decoder
	import bus_pkg::*;
(
	input cpu_addr_t cpu_addr,
	output bus_region_t region,
	output byte_index_t byte_index
);

	logic [7:0] page;

	assign page = cpu_addr[15:8];

	// memories first, then the I/O window
	always_comb
	begin
		region = RG_NONE;
		if (cpu_addr < `AZ_IO_BASE)
		begin
			region = RG_PGROM;
		end
		else if (cpu_addr >= `AZ_WKRAM_BASE)
		begin
			region = RG_WKRAM;
		end
		else if (cpu_addr == `AZ_IO_BASE)
		begin
			region = RG_IN0;
		end
		else if (page == `AZ_JOY_PAGE)
		begin
			region = RG_JOY;
		end
		else if (page == `AZ_PADDLE_PAGE)
		begin
			region = RG_PADDLE;
		end
		else if (page == `AZ_TSTAMP_PAGE)
		begin
			region = RG_TSTAMP;
		end
		else if (page == `AZ_TIMER_PAGE)
		begin
			region = RG_TIMER;
		end
		else if (cpu_addr == `AZ_MENU_ADDR)
		begin
			region = RG_MENU;
		end
		else if (cpu_addr == `AZ_PAUSE_ADDR)
		begin
			region = RG_PAUSE;
		end
	end

	// low bits pick the byte of a multi-byte device
	assign byte_index = cpu_addr[$bits(byte_index_t)-1:0];

endmodule

// File: verilog/aznable_consts.svh
`ifndef AZNABLE_CONSTS_SVH
`define AZNABLE_CONSTS_SVH

// memory array address widths
`define AZ_PGROM_AW 15
`define AZ_WKRAM_AW 14

// memory map
// program ROM below the I/O base, work RAM from its base to the top
`define AZ_IO_BASE 16'h8000
`define AZ_WKRAM_BASE 16'hC000

// I/O pages, compared against address bits 15:8
`define AZ_JOY_PAGE 8'h81
`define AZ_PADDLE_PAGE 8'h84
`define AZ_TSTAMP_PAGE 8'h88
`define AZ_TIMER_PAGE 8'h89

// single-address system triggers
`define AZ_PAUSE_ADDR 16'h8A30
`define AZ_MENU_ADDR 16'h8A31

// readable bytes per input device
// 6 joysticks of 32 buttons each
`define AZ_JOY_BYTES 24
`define AZ_PADDLE_BYTES 6
// 33 bits, bit 32 toggles on change
`define AZ_TSTAMP_BYTES 5

// download index of the program ROM
`define AZ_DN_INDEX_PGROM 8'd0

// clk_24 cycles in one millisecond
`define AZ_MS_DIVIDE 24000

// video timing in ce_6 pixels and lines
`define AZ_H_ACTIVE 320
`define AZ_H_TOTAL 396
`define AZ_V_ACTIVE 240
`define AZ_V_TOTAL 256
`define AZ_HS_START 336
`define AZ_HS_END 368
`define AZ_VS_START 244
`define AZ_VS_END 247

`endif

// File: verilog/aznable_system.sv
`timescale 1ns/10ps

module aznable_system
	import bus_pkg::*;
	import io_pkg::*;
(
	input logic clk_24,
	input logic rst_n,
	input logic ce_6,
	input logic pause,
	input logic menu,
	input dn_addr_t dn_addr,
	input cpu_data_t dn_data,
	input logic dn_wr,
	input dn_index_t dn_index,
	input joystick_t joystick,
	input paddle_t paddle,
	input timestamp_t timestamp,
	input cpu_addr_t cpu_addr,
	input cpu_data_t cpu_dout,
	input logic cpu_wr_n,
	output cpu_data_t cpu_din,
	output logic cpu_wait_n,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_hb,
	output logic vga_vb
);

	bus_region_t region;
	byte_index_t byte_index;
	cpu_data_t mem_rdata;
	ms_count_t timer;
	logic timer_clear;

	address_decoder u_decoder
	(
		.cpu_addr(cpu_addr),
		.region(region),
		.byte_index(byte_index)
	);

	system_memory u_memory
	(
		.clk_24(clk_24),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr_n(cpu_wr_n),
		.region(region),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.dn_wr(dn_wr),
		.dn_index(dn_index),
		.mem_rdata(mem_rdata)
	);

	// blanking and sync are also readable through in0
	io_ports u_io
	(
		.clk_24(clk_24),
		.rst_n(rst_n),
		.region(region),
		.byte_index(byte_index),
		.cpu_wr_n(cpu_wr_n),
		.joystick(joystick),
		.paddle(paddle),
		.timestamp(timestamp),
		.timer(timer),
		.menu(menu),
		.pause(pause),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb),
		.mem_rdata(mem_rdata),
		.cpu_din(cpu_din),
		.cpu_wait_n(cpu_wait_n),
		.timer_clear(timer_clear)
	);

	ms_timer u_ms_timer
	(
		.clk_24(clk_24),
		.rst_n(rst_n),
		.clear(timer_clear),
		.count(timer)
	);

	video_timer u_video
	(
		.clk_24(clk_24),
		.rst_n(rst_n),
		.ce_6(ce_6),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb)
	);

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

	// processor side of the system bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// loader side, used only to fill the program ROM
	typedef logic [23:0] dn_addr_t;
	typedef logic [7:0] dn_index_t;

	// decoded target of a processor access
	typedef enum logic [3:0]
	{
		RG_NONE,
		RG_PGROM,
		RG_WKRAM,
		RG_IN0,
		RG_JOY,
		RG_PADDLE,
		RG_TSTAMP,
		RG_TIMER,
		RG_PAUSE,
		RG_MENU
	} bus_region_t;

	// byte offset inside a multi-byte device
	typedef logic [4:0] byte_index_t;

endpackage

// File: verilog/io_pkg.sv
package io_pkg;

	// 6 devices, 32 buttons each
	typedef logic [191:0] joystick_t;

	// 6 devices, 8 bits each
	typedef logic [47:0] paddle_t;

	// seconds count in 31:0, bit 32 toggles with every change
	typedef logic [32:0] timestamp_t;

	// free running millisecond count, wraps
	typedef logic [15:0] ms_count_t;

	// horizontal and vertical beam position
	typedef logic [8:0] pixel_count_t;

endpackage

// File: verilog/io_ports.sv
`timescale 1ns/10ps
`include "aznable_consts.svh"

module io_ports
	import bus_pkg::*;
	import io_pkg::*;
(
	input logic clk_24,
	input logic rst_n,
	input bus_region_t region,
	input byte_index_t byte_index,
	input logic cpu_wr_n,
	input joystick_t joystick,
	input paddle_t paddle,
	input timestamp_t timestamp,
	input ms_count_t timer,
	input logic menu,
	input logic pause,
	input logic vga_hs,
	input logic vga_vs,
	input logic vga_hb,
	input logic vga_vb,
	input cpu_data_t mem_rdata,
	output cpu_data_t cpu_din,
	output logic cpu_wait_n,
	output logic timer_clear
);

	localparam int TIMER_BYTES = $bits(ms_count_t) / 8;

	cpu_data_t dev_byte;
	cpu_data_t io_q;
	bus_region_t region_q;
	logic menu_trigger;
	logic pause_trigger;
	logic menu_wr;
	logic pause_wr;

	// byte k of a device is bits 8k+7:8k, anything past its size reads zero
	function automatic cpu_data_t pick_byte(input logic [255:0] wide, input byte_index_t idx,
		input int nbytes);
		cpu_data_t b;
		b = '0;
		if (int'(idx) < nbytes)
		begin
			b = wide[{idx, 3'b000} +: 8];
		end
		return b;
	endfunction

	assign menu_wr = !cpu_wr_n && (region == RG_MENU);
	assign pause_wr = !cpu_wr_n && (region == RG_PAUSE);
	assign timer_clear = !cpu_wr_n && (region == RG_TIMER);

	always_comb
	begin
		case (region)
			RG_IN0: dev_byte = {vga_hs, vga_vs, vga_hb, vga_vb, 2'b10, menu, 1'b0};
			RG_JOY: dev_byte = pick_byte(256'(joystick), byte_index, `AZ_JOY_BYTES);
			RG_PADDLE: dev_byte = pick_byte(256'(paddle), byte_index, `AZ_PADDLE_BYTES);
			RG_TSTAMP: dev_byte = pick_byte(256'(timestamp), byte_index, `AZ_TSTAMP_BYTES);
			RG_TIMER: dev_byte = pick_byte(256'(timer), byte_index, TIMER_BYTES);
			RG_MENU: dev_byte = {8{menu_trigger}};
			default: dev_byte = '0;
		endcase
	end

	// menu input sets, a processor write acknowledges
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			menu_trigger <= 1'b0;
		end
		else if (menu_wr)
		begin
			menu_trigger <= 1'b0;
		end
		else if (menu)
		begin
			menu_trigger <= 1'b1;
		end
	end

	// processor requests a pause, external pause releases it
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			pause_trigger <= 1'b0;
		end
		else if (pause)
		begin
			pause_trigger <= 1'b0;
		end
		else if (pause_wr)
		begin
			pause_trigger <= 1'b1;
		end
	end

	assign cpu_wait_n = !(pause || pause_trigger);

	// same edge as the memory read so both sources arrive together
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			region_q <= RG_NONE;
			io_q <= '0;
		end
		else
		begin
			region_q <= region;
			io_q <= dev_byte;
		end
	end

	assign cpu_din = ((region_q == RG_PGROM) || (region_q == RG_WKRAM)) ? mem_rdata : io_q;

endmodule

// File: verilog/ms_timer.sv
`timescale 1ns/10ps
`include "aznable_consts.svh"

module ms_timer
	import io_pkg::*;
(
	input logic clk_24,
	input logic rst_n,
	input logic clear,
	output ms_count_t count
);

	localparam int PRE_W = $clog2(`AZ_MS_DIVIDE);

	logic [PRE_W-1:0] prescale;

	// clear restarts the millisecond too, not just the count
	always_ff @(posedge clk_24)
	begin
		if (!rst_n || clear)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (prescale == PRE_W'(`AZ_MS_DIVIDE - 1))
		begin
			prescale <= '0;
			count <= count + 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// File: verilog/system_memory.sv
`timescale 1ns/10ps
`include "aznable_consts.svh"

module system_memory
	import bus_pkg::*;
(
	input logic clk_24,
	input cpu_addr_t cpu_addr,
	input cpu_data_t cpu_dout,
	input logic cpu_wr_n,
	input bus_region_t region,
	input dn_addr_t dn_addr,
	input cpu_data_t dn_data,
	input logic dn_wr,
	input dn_index_t dn_index,
	output cpu_data_t mem_rdata
);

	// program ROM 0x0000 - 0x7FFF, work RAM 0xC000 - 0xFFFF
	cpu_data_t pgrom [0:(2**`AZ_PGROM_AW)-1];
	cpu_data_t wkram [0:(2**`AZ_WKRAM_AW)-1];

	cpu_data_t pgrom_q;
	cpu_data_t wkram_q;
	logic wkram_sel;
	logic pgrom_wr;
	logic wkram_wr;

	// the processor never writes the ROM, only the loader does
	assign pgrom_wr = dn_wr && (dn_index == `AZ_DN_INDEX_PGROM);
	assign wkram_wr = !cpu_wr_n && (region == RG_WKRAM);

	always_ff @(posedge clk_24)
	begin
		if (pgrom_wr)
		begin
			pgrom[dn_addr[`AZ_PGROM_AW-1:0]] <= dn_data;
		end
		pgrom_q <= pgrom[cpu_addr[`AZ_PGROM_AW-1:0]];
	end

	always_ff @(posedge clk_24)
	begin
		if (wkram_wr)
		begin
			wkram[cpu_addr[`AZ_WKRAM_AW-1:0]] <= cpu_dout;
		end
		wkram_q <= wkram[cpu_addr[`AZ_WKRAM_AW-1:0]];
	end

	// remember which array was addressed so the byte lines up with its read
	always_ff @(posedge clk_24)
	begin
		wkram_sel <= (region == RG_WKRAM);
	end

	assign mem_rdata = wkram_sel ? wkram_q : pgrom_q;

endmodule

// File: verilog/video_timer.sv
`timescale 1ns/10ps
`include "aznable_consts.svh"

module video_timer
	import io_pkg::*;
(
	input logic clk_24,
	input logic rst_n,
	input logic ce_6,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_hb,
	output logic vga_vb
);

	localparam int PW = $bits(pixel_count_t);

	pixel_count_t hcnt;
	pixel_count_t vcnt;
	logic line_end;
	logic frame_end;

	assign line_end = (hcnt == PW'(`AZ_H_TOTAL - 1));
	assign frame_end = (vcnt == PW'(`AZ_V_TOTAL - 1));

	// one pixel per ce_6, line count steps at the end of each line
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (ce_6)
		begin
			if (line_end)
			begin
				hcnt <= '0;
				vcnt <= frame_end ? '0 : vcnt + 1'b1;
			end
			else
			begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// blanking covers everything past the visible area
	assign vga_hb = (hcnt >= PW'(`AZ_H_ACTIVE));
	assign vga_vb = (vcnt >= PW'(`AZ_V_ACTIVE));

	// sync windows are start inclusive, end exclusive
	assign vga_hs = (hcnt >= PW'(`AZ_HS_START)) && (hcnt < PW'(`AZ_HS_END));
	assign vga_vs = (vcnt >= PW'(`AZ_VS_START)) && (vcnt < PW'(`AZ_VS_END));

endmodule
